// File: hdl/icache_pkg.sv
// instruction cache front end shared constants and types
package icache_pkg;

  localparam int NUM_WAYS  = 4;
  localparam int SETS_LOG2 = 8;   // set index from address bits 11..4
  localparam int PKG_W     = 32;

  localparam logic [31:0] NOP_INST = 32'h0010_0000;   // add.w r0, r0, r0

  typedef struct packed {
    logic        valid;
    logic [19:0] ptag;   // physical page
  } way_tag_t;

  // one refill write, broadcast to all ways and to F1
  typedef struct packed {
    logic                 we;
    logic [3:0]           way;   // one-hot
    logic [SETS_LOG2-1:0] set;
    way_tag_t             tag;
    logic [127:0]         data;
  } way_wr_t;

  typedef struct packed {
    logic        used;     // entry holds a mapping
    logic [19:0] vpage;
    logic [19:0] ppage;
    logic        v;        // page valid
    logic [1:0]  plv;
    logic        cached;
  } tlb_entry_t;

  typedef struct packed {
    logic       we;
    logic [3:0] idx;
    tlb_entry_t entry;
  } tlb_update_t;

  typedef struct packed {
    logic       found;
    tlb_entry_t entry;
  } tlb_resp_t;

  typedef struct packed {
    logic [1:0] plv;
    logic       da;   // direct address mode
  } csr_t;

  typedef struct packed {
    logic adef;
    logic tlbr;
    logic pif;
    logic ppi;
  } fetch_excp_t;

  typedef struct packed {
    logic        valid;
    logic        unc;
    logic [31:0] addr;
  } bus_req_t;

  typedef struct packed {
    logic         ready;   // one-cycle strobe
    logic [127:0] rdata;
  } bus_resp_t;

endpackage

// File: hdl/icache_tlb.sv
// direct-mapped 16-entry instruction TLB with registered lookup
`timescale 1ns/1ps

module icache_tlb (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    en_i,
  input  logic [19:0]             vpage_i,
  input  icache_pkg::csr_t        csr_i,
  input  icache_pkg::tlb_update_t upd_i,
  output icache_pkg::tlb_resp_t   resp_o
);
  import icache_pkg::*;

  tlb_entry_t entry_mem [16];
  logic [15:0] used_q;
  tlb_entry_t  entry_rd;
  tlb_resp_t   resp_d;
  tlb_resp_t   resp_q;

  assign entry_rd = entry_mem[vpage_i[3:0]];

  always_comb
  begin
    if (csr_i.da)
    begin
      // identity mapping, cached, any privilege
      resp_d.found        = 1'b1;
      resp_d.entry.used   = 1'b1;
      resp_d.entry.vpage  = vpage_i;
      resp_d.entry.ppage  = vpage_i;
      resp_d.entry.v      = 1'b1;
      resp_d.entry.plv    = 2'd3;
      resp_d.entry.cached = 1'b1;
    end
    else
    begin
      resp_d.found = used_q[vpage_i[3:0]] && (entry_rd.vpage == vpage_i);
      resp_d.entry = entry_rd;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      used_q <= '0;
    end
    else if (upd_i.we)
    begin
      used_q[upd_i.idx] <= upd_i.entry.used;
    end
  end

  always_ff @(posedge clk)
  begin
    if (upd_i.we)
      entry_mem[upd_i.idx] <= upd_i.entry;
    if (en_i)
      resp_q <= resp_d;   // held while the fetch stalls
  end

  assign resp_o = resp_q;

endmodule

// File: hdl/icache_way.sv
// one instruction cache way, tag and valid plus two 64-bit halves per set
`timescale 1ns/1ps

module icache_way #(
  parameter int SETS_LOG2 = icache_pkg::SETS_LOG2
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [SETS_LOG2-1:0] rd_set_i,
  input  logic                 rd_half_i,
  input  icache_pkg::way_wr_t  wr_i,
  input  logic                 way_sel_i,
  output icache_pkg::way_tag_t tag_o,
  output logic [63:0]          data_o
);
  import icache_pkg::*;

  localparam int SETS = 1 << SETS_LOG2;

  logic [19:0]     tag_mem [SETS];
  logic [63:0]     lo_mem [SETS];
  logic [63:0]     hi_mem [SETS];
  logic [SETS-1:0] valid_q;
  logic            rd_valid_q;
  logic [19:0]     rd_ptag_q;
  logic            we;
  logic            wr_same_set;

  assign we          = wr_i.we && way_sel_i;
  assign wr_same_set = we && (wr_i.set == rd_set_i);   // read returns the new line

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      valid_q    <= '0;
      rd_valid_q <= 1'b0;
    end
    else
    begin
      if (we)
        valid_q[wr_i.set] <= wr_i.tag.valid;
      rd_valid_q <= wr_same_set ? wr_i.tag.valid : valid_q[rd_set_i];
    end
  end

  always_ff @(posedge clk)
  begin
    if (we)
    begin
      tag_mem[wr_i.set] <= wr_i.tag.ptag;
      lo_mem[wr_i.set]  <= wr_i.data[63:0];
      hi_mem[wr_i.set]  <= wr_i.data[127:64];
    end
    if (wr_same_set)
    begin
      rd_ptag_q <= wr_i.tag.ptag;
      data_o    <= rd_half_i ? wr_i.data[127:64] : wr_i.data[63:0];
    end
    else
    begin
      rd_ptag_q <= tag_mem[rd_set_i];
      data_o    <= rd_half_i ? hi_mem[rd_set_i] : lo_mem[rd_set_i];
    end
  end

  assign tag_o = '{valid: rd_valid_q, ptag: rd_ptag_q};

endmodule

// File: hdl/icache_refill.sv
// refill controller, line and uncached bus reads with round-robin victim
`timescale 1ns/1ps

module icache_refill #(
  parameter int NUM_WAYS = icache_pkg::NUM_WAYS
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  miss_req_i,
  input  logic [31:0]           miss_addr_i,
  input  logic                  miss_unc_i,
  input  icache_pkg::bus_resp_t bus_resp_i,
  output icache_pkg::bus_req_t  bus_req_o,
  output icache_pkg::way_wr_t   way_wr_o,
  output logic                  refill_done_o,
  output logic [1:0][31:0]      refill_data_o
);
  import icache_pkg::*;

  localparam int VW = $clog2(NUM_WAYS);

  typedef enum logic { R_IDLE, R_BUSY } state_t;

  state_t        state_q;
  logic [VW-1:0] victim_q;
  logic [31:0]   addr_q;
  logic          unc_q;
  logic          strobe;
  logic          start;

  assign start  = (state_q == R_IDLE) && miss_req_i;
  assign strobe = (state_q == R_BUSY) && bus_resp_i.ready;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q  <= R_IDLE;
      victim_q <= '0;
    end
    else
    begin
      if (start)
        state_q <= R_BUSY;
      else if (strobe)
        state_q <= R_IDLE;   // valid drops the cycle after the strobe
      if (strobe && !unc_q)
        victim_q <= (victim_q == VW'(NUM_WAYS - 1)) ? '0 : victim_q + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      addr_q <= miss_addr_i;
      unc_q  <= miss_unc_i;
    end
  end

  always_comb
  begin
    bus_req_o.valid = (state_q == R_BUSY);
    bus_req_o.unc   = unc_q;
    bus_req_o.addr  = unc_q ? {addr_q[31:3], 3'b000} : {addr_q[31:4], 4'b0000};
  end

  // line write into the victim, same cycle as the strobe
  always_comb
  begin
    way_wr_o               = '0;
    way_wr_o.we            = strobe && !unc_q;
    way_wr_o.way[victim_q] = 1'b1;
    way_wr_o.set           = addr_q[4 +: SETS_LOG2];
    way_wr_o.tag           = '{valid: 1'b1, ptag: addr_q[31:12]};
    way_wr_o.data          = bus_resp_i.rdata;
  end

  assign refill_done_o = strobe;
  // uncached data sits in the low doubleword
  assign refill_data_o = (!unc_q && addr_q[3]) ? bus_resp_i.rdata[127:64]
                                               : bus_resp_i.rdata[63:0];

endmodule

// File: hdl/icache_fetch.sv
// two-stage fetch pipeline with skid buffer, hit select and miss FSM
`timescale 1ns/1ps

module icache_fetch #(
  parameter int NUM_WAYS = icache_pkg::NUM_WAYS,
  parameter int PKG_W    = icache_pkg::PKG_W
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                f_valid_i,
  output logic                                f_ready_o,
  input  logic [31:0]                         f_pc_i,
  input  logic [1:0]                          f_mask_i,
  input  logic [PKG_W-1:0]                    f_pkg_i,
  output logic                                f_valid_o,
  input  logic                                f_ready_i,
  output logic [31:0]                         f_pc_o,
  output logic [1:0]                          f_mask_o,
  output logic [PKG_W-1:0]                    f_pkg_o,
  output logic [1:0][31:0]                    f_inst_o,
  output icache_pkg::fetch_excp_t             f_excp_o,
  input  icache_pkg::csr_t                    csr_i,
  input  icache_pkg::tlb_resp_t               tlb_resp_i,
  input  icache_pkg::way_tag_t [NUM_WAYS-1:0] way_tag_i,
  input  logic [NUM_WAYS-1:0][63:0]           way_data_i,
  input  icache_pkg::way_wr_t                 way_wr_i,
  input  logic                                refill_done_i,
  input  logic [1:0][31:0]                    refill_data_i,
  input  logic                                flush_i,
  output logic                                tlb_en_o,
  output logic [19:0]                         vpage_o,
  output logic [icache_pkg::SETS_LOG2-1:0]    rd_set_o,
  output logic                                rd_half_o,
  output logic                                miss_req_o,
  output logic [31:0]                         miss_addr_o,
  output logic                                miss_unc_o
);
  import icache_pkg::*;

  typedef struct packed {
    logic [1:0]       mask;
    logic [31:0]      pc;
    logic [PKG_W-1:0] pkg;
  } req_t;

  typedef struct packed {
    logic [31:0]               pc;
    logic [31:0]               addr;   // physical
    logic [1:0]                mask;
    logic                      unc;
    logic [PKG_W-1:0]          pkg;
    way_tag_t [NUM_WAYS-1:0]   tag;
    logic [NUM_WAYS-1:0][63:0] data;   // selected half of each way
    fetch_excp_t               excp;
  } f1_pack_t;

  typedef enum logic [1:0] {
    S_FREE,
    S_HANDLED,   // words ready, waiting on the consumer
    S_REFILL,
    S_UNC
  } fsm_t;

  req_t            req_q;
  logic            f1_valid_q;
  logic            skid_busy_q;
  f1_pack_t        f1_raw;
  f1_pack_t        f1;
  f1_pack_t        skid_q;
  logic [NUM_WAYS-1:0] f1_hit;
  logic            f1_f2_valid;
  logic            f1_f2_ready;

  f1_pack_t        f2_q;
  logic [NUM_WAYS-1:0] f2_hit_q;
  logic            f2_valid_q;
  logic            has_excp;
  logic            need_bus;
  logic [1:0][31:0] hit_dw;
  logic [1:0][31:0] out_dw;
  logic [1:0][31:0] fsm_data_q;
  fsm_t            fsm;
  fsm_t            fsm_q;

  assign f_ready_o   = !skid_busy_q;
  assign f1_f2_valid = f1_valid_q || skid_busy_q;
  assign tlb_en_o    = f_ready_o;
  assign vpage_o     = f_pc_i[31:12];

  // while stalled, keep re-reading the held request so refills are seen
  assign rd_set_o  = skid_busy_q ? req_q.pc[4 +: SETS_LOG2] : f_pc_i[4 +: SETS_LOG2];
  assign rd_half_o = skid_busy_q ? req_q.pc[3] : f_pc_i[3];

  always_comb
  begin
    f1_raw.pc        = req_q.pc;
    f1_raw.addr      = {tlb_resp_i.entry.ppage, req_q.pc[11:0]};
    f1_raw.mask      = req_q.mask;
    f1_raw.unc       = !tlb_resp_i.entry.cached;
    f1_raw.pkg       = req_q.pkg;
    f1_raw.tag       = way_tag_i;
    f1_raw.data      = way_data_i;
    // priority adef > tlbr > pif > ppi
    f1_raw.excp.adef = |req_q.pc[1:0];
    f1_raw.excp.tlbr = !f1_raw.excp.adef && !tlb_resp_i.found;
    f1_raw.excp.pif  = !f1_raw.excp.adef && !f1_raw.excp.tlbr && !tlb_resp_i.entry.v;
    f1_raw.excp.ppi  = !f1_raw.excp.adef && !f1_raw.excp.tlbr && !f1_raw.excp.pif
                       && (tlb_resp_i.entry.plv == 2'd0) && (csr_i.plv == 2'd3);
  end

  // forward a refill write landing on the set held in F1
  always_comb
  begin
    f1 = skid_busy_q ? skid_q : f1_raw;
    if (way_wr_i.we && (way_wr_i.set == f1.addr[4 +: SETS_LOG2]))
    begin
      for (int w = 0; w < NUM_WAYS; w++)
      begin
        if (way_wr_i.way[w])
        begin
          f1.tag[w]  = way_wr_i.tag;
          f1.data[w] = f1.addr[3] ? way_wr_i.data[127:64] : way_wr_i.data[63:0];
        end
      end
    end
  end

  always_comb
  begin
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      f1_hit[w] = f1.tag[w].valid && (f1.tag[w].ptag == f1.addr[31:12]);
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
    begin
      f1_valid_q  <= 1'b0;
      skid_busy_q <= 1'b0;
      f2_valid_q  <= 1'b0;
    end
    else
    begin
      if (f_ready_o)
        f1_valid_q <= f_valid_i;
      if (skid_busy_q)
        skid_busy_q <= !f1_f2_ready;
      else
        skid_busy_q <= f1_valid_q && !f1_f2_ready;
      if (f1_f2_ready)
        f2_valid_q <= f1_f2_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (f_ready_o)
      req_q <= '{mask: f_mask_i, pc: f_pc_i, pkg: f_pkg_i};
    skid_q <= f1;   // refreshed every cycle, forwarding included
    if (f1_f2_ready)
    begin
      f2_q     <= f1;
      f2_hit_q <= f1_hit;
    end
    if (refill_done_i)
      fsm_data_q <= refill_data_i;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      fsm_q <= S_FREE;
    else
      fsm_q <= fsm;
  end

  assign has_excp = |f2_q.excp;
  assign need_bus = f2_valid_q && (|f2_q.mask) && !has_excp
                    && (f2_q.unc || !(|f2_hit_q));

  always_comb
  begin
    hit_dw = '0;
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      if (f2_hit_q[w])
        hit_dw |= f2_q.data[w];
    end
  end

  always_comb
  begin
    fsm         = fsm_q;
    f1_f2_ready = 1'b0;
    f_valid_o   = 1'b0;
    miss_req_o  = 1'b0;
    miss_unc_o  = f2_q.unc;
    out_dw      = hit_dw;
    case (fsm_q)
      S_FREE:
      begin
        if (need_bus)
        begin
          miss_req_o = 1'b1;
          fsm        = f2_q.unc ? S_UNC : S_REFILL;
        end
        else
        begin
          f_valid_o   = f2_valid_q;
          f1_f2_ready = f_ready_i || !f2_valid_q;
        end
      end
      S_REFILL, S_UNC:
      begin
        miss_req_o = 1'b1;
        miss_unc_o = (fsm_q == S_UNC);
        if (refill_done_i)
          fsm = S_HANDLED;
      end
      default:
      begin
        out_dw      = fsm_data_q;
        f_valid_o   = f2_valid_q;   // low here if flushed during the read
        f1_f2_ready = f_ready_i || !f2_valid_q;
        if (f1_f2_ready)
          fsm = S_FREE;
      end
    endcase
  end

  assign miss_addr_o = f2_q.addr;
  assign f_pc_o      = f2_q.pc;
  assign f_mask_o    = f2_q.mask;
  assign f_pkg_o     = f2_q.pkg;
  assign f_excp_o    = f2_q.excp;

  // slot 0 is the word at pc, slot 1 the word after it
  always_comb
  begin
    if (has_excp)
    begin
      f_inst_o[0] = NOP_INST;
      f_inst_o[1] = NOP_INST;
    end
    else
    begin
      f_inst_o[0] = f2_q.pc[2] ? out_dw[1] : out_dw[0];
      f_inst_o[1] = out_dw[1];
    end
  end

endmodule

// File: hdl/icache_top.sv
// instruction cache front end, TLB, fetch pipeline, refill and ways
`timescale 1ns/1ps

module icache_top #(
  parameter int NUM_WAYS = icache_pkg::NUM_WAYS,
  parameter int PKG_W    = icache_pkg::PKG_W
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    f_valid_i,
  output logic                    f_ready_o,
  input  logic [31:0]             f_pc_i,
  input  logic [1:0]              f_mask_i,
  input  logic [PKG_W-1:0]        f_pkg_i,
  output logic                    f_valid_o,
  input  logic                    f_ready_i,
  output logic [31:0]             f_pc_o,
  output logic [1:0]              f_mask_o,
  output logic [PKG_W-1:0]        f_pkg_o,
  output logic [1:0][31:0]        f_inst_o,
  output icache_pkg::fetch_excp_t f_excp_o,
  input  icache_pkg::csr_t        csr_i,
  input  icache_pkg::tlb_update_t tlb_update_i,
  output icache_pkg::bus_req_t    bus_req_o,
  input  icache_pkg::bus_resp_t   bus_resp_i,
  input  logic                    flush_i
);
  import icache_pkg::*;

  tlb_resp_t                 tlb_resp;
  logic                      tlb_en;
  logic [19:0]               vpage;
  logic [SETS_LOG2-1:0]      rd_set;
  logic                      rd_half;
  way_tag_t [NUM_WAYS-1:0]   way_tag;
  logic [NUM_WAYS-1:0][63:0] way_data;
  way_wr_t                   way_wr;
  logic                      miss_req;
  logic [31:0]               miss_addr;
  logic                      miss_unc;
  logic                      refill_done;
  logic [1:0][31:0]          refill_data;

  icache_tlb i_tlb (
    .clk     (clk),
    .rst_n   (rst_n),
    .en_i    (tlb_en),
    .vpage_i (vpage),
    .csr_i   (csr_i),
    .upd_i   (tlb_update_i),
    .resp_o  (tlb_resp)
  );

  icache_fetch #(
    .NUM_WAYS (NUM_WAYS),
    .PKG_W    (PKG_W)
  ) i_fetch (
    .clk           (clk),
    .rst_n         (rst_n),
    .f_valid_i     (f_valid_i),
    .f_ready_o     (f_ready_o),
    .f_pc_i        (f_pc_i),
    .f_mask_i      (f_mask_i),
    .f_pkg_i       (f_pkg_i),
    .f_valid_o     (f_valid_o),
    .f_ready_i     (f_ready_i),
    .f_pc_o        (f_pc_o),
    .f_mask_o      (f_mask_o),
    .f_pkg_o       (f_pkg_o),
    .f_inst_o      (f_inst_o),
    .f_excp_o      (f_excp_o),
    .csr_i         (csr_i),
    .tlb_resp_i    (tlb_resp),
    .way_tag_i     (way_tag),
    .way_data_i    (way_data),
    .way_wr_i      (way_wr),
    .refill_done_i (refill_done),
    .refill_data_i (refill_data),
    .flush_i       (flush_i),
    .tlb_en_o      (tlb_en),
    .vpage_o       (vpage),
    .rd_set_o      (rd_set),
    .rd_half_o     (rd_half),
    .miss_req_o    (miss_req),
    .miss_addr_o   (miss_addr),
    .miss_unc_o    (miss_unc)
  );

  icache_refill #(
    .NUM_WAYS (NUM_WAYS)
  ) i_refill (
    .clk           (clk),
    .rst_n         (rst_n),
    .miss_req_i    (miss_req),
    .miss_addr_i   (miss_addr),
    .miss_unc_i    (miss_unc),
    .bus_resp_i    (bus_resp_i),
    .bus_req_o     (bus_req_o),
    .way_wr_o      (way_wr),
    .refill_done_o (refill_done),
    .refill_data_o (refill_data)
  );

  for (genvar w = 0; w < NUM_WAYS; w++)
  begin : g_way
    icache_way #(
      .SETS_LOG2 (SETS_LOG2)
    ) i_way (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_set_i  (rd_set),
      .rd_half_i (rd_half),
      .wr_i      (way_wr),
      .way_sel_i (way_wr.way[w]),
      .tag_o     (way_tag[w]),
      .data_o    (way_data[w])
    );
  end

endmodule

// File: test/tb_icache.sv
// testbench for the instruction cache front end, directed fetches against a bus memory model
`timescale 1ns/1ps

module tb_icache;
  import icache_pkg::*;

  localparam int          MAX_CYCLES = 4000;
  localparam logic [31:0] MEM_KEY    = 32'h5a5a_0000;
  // flag order in fetch_excp_t is adef, tlbr, pif, ppi
  localparam logic [3:0]  EX_NONE = 4'b0000;
  localparam logic [3:0]  EX_ADEF = 4'b1000;
  localparam logic [3:0]  EX_TLBR = 4'b0100;
  localparam logic [3:0]  EX_PIF  = 4'b0010;
  localparam logic [3:0]  EX_PPI  = 4'b0001;

  typedef struct packed {
    logic [31:0] pc;
    logic [1:0]  mask;
    logic [31:0] pkg;
    logic [31:0] inst1;
    logic [31:0] inst0;
    logic [3:0]  excp;
  } resp_rec_t;

  logic             clk = 1'b0;
  logic             rst_n;
  logic             f_valid_i;
  logic             f_ready_o;
  logic [31:0]      f_pc_i;
  logic [1:0]       f_mask_i;
  logic [31:0]      f_pkg_i;
  logic             f_valid_o;
  logic             f_ready_i = 1'b0;   // driven by the response consumer
  logic [31:0]      f_pc_o;
  logic [1:0]       f_mask_o;
  logic [31:0]      f_pkg_o;
  logic [1:0][31:0] f_inst_o;
  fetch_excp_t      f_excp_o;
  csr_t             csr_i;
  tlb_update_t      tlb_update_i;
  bus_req_t         bus_req_o;
  bus_resp_t        bus_resp_i = '0;    // driven by the memory model
  logic             flush_i;

  resp_rec_t exp_q[$];
  resp_rec_t got_q[$];
  resp_rec_t held_resp;
  bus_req_t  last_req;   // most recent request taken by the memory
  logic      held = 1'b0;
  logic      bp_mode = 1'b0;
  logic      mem_busy = 1'b0;
  int        mem_delay = 0;
  int        req_count = 0;
  int        cycles = 0;
  int        errors = 0;
  int        checks = 0;
  int        tests_run = 0;

  icache_top #(
    .NUM_WAYS (4),
    .PKG_W    (32)
  ) i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .f_valid_i    (f_valid_i),
    .f_ready_o    (f_ready_o),
    .f_pc_i       (f_pc_i),
    .f_mask_i     (f_mask_i),
    .f_pkg_i      (f_pkg_i),
    .f_valid_o    (f_valid_o),
    .f_ready_i    (f_ready_i),
    .f_pc_o       (f_pc_o),
    .f_mask_o     (f_mask_o),
    .f_pkg_o      (f_pkg_o),
    .f_inst_o     (f_inst_o),
    .f_excp_o     (f_excp_o),
    .csr_i        (csr_i),
    .tlb_update_i (tlb_update_i),
    .bus_req_o    (bus_req_o),
    .bus_resp_i   (bus_resp_i),
    .flush_i      (flush_i)
  );

  always #10 clk = ~clk;

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout, the run was stopped after %0d cycles", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic check(input string what, input logic [159:0] got, input logic [159:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // memory content is the word address xor a key
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ MEM_KEY;
  endfunction

  task automatic serve_bus();
    int i;
    if (bus_resp_i.ready)
      bus_resp_i.ready = 1'b0;   // one-cycle strobe
    else if (bus_req_o.valid && !mem_busy)
    begin
      mem_busy  = 1'b1;
      mem_delay = 1 + int'($urandom % 6);
      last_req  = bus_req_o;
      req_count++;
    end
    else if (mem_busy)
    begin
      mem_delay--;
      if (mem_delay == 0)
      begin
        for (i = 0; i < 4; i++)
          bus_resp_i.rdata[32*i +: 32] = mem_word(bus_req_o.addr + 32'(4 * i));
        bus_resp_i.ready = 1'b1;
        mem_busy         = 1'b0;
      end
    end
  endtask

  // decides f_ready_i for the next edge and records what that edge consumes
  task automatic take_response();
    resp_rec_t cur;
    cur = '{pc: f_pc_o, mask: f_mask_o, pkg: f_pkg_o, inst1: f_inst_o[1],
            inst0: f_inst_o[0], excp: f_excp_o};
    if (held)
    begin
      check("valid while held", f_valid_o, 1'b1);
      check("outputs while held", cur, held_resp);
    end
    f_ready_i = bp_mode ? (($urandom % 3) != 0) : 1'b1;
    if (f_valid_o && f_ready_i)
      got_q.push_back(cur);
    held      = f_valid_o && !f_ready_i;
    held_resp = cur;
  endtask

  always @(negedge clk)
  begin
    if (rst_n)
    begin
      serve_bus();
      take_response();
    end
  end

  task automatic map_page(input logic [19:0] vpage, input logic [19:0] ppage, input logic v,
                          input logic [1:0] plv, input logic cached);
    tlb_update_i.we    = 1'b1;
    tlb_update_i.idx   = vpage[3:0];
    tlb_update_i.entry = '{used: 1'b1, vpage: vpage, ppage: ppage, v: v, plv: plv,
                           cached: cached};
    @(negedge clk);
    tlb_update_i.we = 1'b0;
  endtask

  task automatic expect_resp(input logic [31:0] pc, input logic [1:0] mask,
                             input logic [31:0] pkg, input logic [31:0] paddr,
                             input logic [3:0] excp);
    resp_rec_t e;
    e.pc   = pc;
    e.mask = mask;
    e.pkg  = pkg;
    e.excp = excp;
    e.inst0 = (excp != EX_NONE) ? NOP_INST : mem_word(paddr);
    e.inst1 = (excp != EX_NONE) ? NOP_INST : mem_word(paddr + 32'd4);
    exp_q.push_back(e);
  endtask

  task automatic issue(input logic [31:0] pc, input logic [1:0] mask, input logic [31:0] pkg);
    f_valid_i = 1'b1;
    f_pc_i    = pc;
    f_mask_i  = mask;
    f_pkg_i   = pkg;
    while (!f_ready_o)
      @(negedge clk);
    @(negedge clk);   // taken on the edge just passed
    f_valid_i = 1'b0;
  endtask

  task automatic fetch(input logic [31:0] pc, input logic [1:0] mask, input logic [31:0] pkg,
                       input logic [31:0] paddr, input logic [3:0] excp);
    expect_resp(pc, mask, pkg, paddr, excp);
    issue(pc, mask, pkg);
  endtask

  // waits for all expected responses, then compares them in order
  task automatic drain();
    resp_rec_t e;
    resp_rec_t g;
    while (got_q.size() < exp_q.size())
      @(negedge clk);
    repeat (4) @(negedge clk);
    check("response count", got_q.size(), exp_q.size());
    while (exp_q.size() > 0 && got_q.size() > 0)
    begin
      e = exp_q.pop_front();
      g = got_q.pop_front();
      check($sformatf("pc of fetch %h", e.pc), g.pc, e.pc);
      check($sformatf("mask at pc %h", e.pc), g.mask, e.mask);
      check($sformatf("pkg at pc %h", e.pc), g.pkg, e.pkg);
      check($sformatf("exception flags at pc %h", e.pc), g.excp, e.excp);
      if (e.mask[0] || e.excp != EX_NONE)
        check($sformatf("slot 0 at pc %h", e.pc), g.inst0, e.inst0);
      if (e.mask[1] || e.excp != EX_NONE)
        check($sformatf("slot 1 at pc %h", e.pc), g.inst1, e.inst1);
    end
    exp_q.delete();
    got_q.delete();
  endtask

  task automatic report(input string name, input int err_before);
    tests_run++;
    if (errors == err_before)
      $display("%s: passed", name);
    else
      $display("%s: %0d errors", name, errors - err_before);
  endtask

  task automatic miss_then_hit();
    int e0;
    int n0;
    int i;
    logic [31:0] pc;
    e0 = errors;
    csr_i = '{plv: 2'd0, da: 1'b1};
    n0 = req_count;
    fetch(32'h0000_2010, 2'b11, 32'h11, 32'h0000_2010, EX_NONE);
    drain();
    check("bus requests for first fetch", req_count - n0, 1);
    check("bus request for first fetch", {last_req.unc, last_req.addr},
          {1'b0, 32'h0000_2010});
    n0 = req_count;
    fetch(32'h0000_2018, 2'b11, 32'h12, 32'h0000_2018, EX_NONE);
    drain();
    check("bus requests for same line", req_count - n0, 0);
    n0 = req_count;
    for (i = 0; i < 8; i++)
    begin
      pc = 32'h0000_2010 + 32'(4 * (i % 4));   // stays in the cached line
      fetch(pc, pc[2] ? 2'b01 : 2'b11, 32'h20 + 32'(i), pc, EX_NONE);   // back to back
    end
    drain();
    check("bus requests for hit stream", req_count - n0, 0);
    report("miss then hit", e0);
  endtask

  task automatic uncached_fetches();
    int e0;
    int n0;
    e0 = errors;
    csr_i = '{plv: 2'd0, da: 1'b0};
    map_page(20'h00012, 20'h00345, 1'b1, 2'd3, 1'b0);
    n0 = req_count;
    fetch(32'h0001_2008, 2'b01, 32'h31, 32'h0034_5008, EX_NONE);
    drain();
    check("bus requests, uncached low word", req_count - n0, 1);
    n0 = req_count;
    fetch(32'h0001_200c, 2'b01, 32'h32, 32'h0034_500c, EX_NONE);
    drain();
    check("bus requests, uncached high word", req_count - n0, 1);
    check("bus request, uncached high word", {last_req.unc, last_req.addr},
          {1'b1, 32'h0034_5008});
    n0 = req_count;
    fetch(32'h0001_2008, 2'b01, 32'h33, 32'h0034_5008, EX_NONE);
    drain();
    check("bus requests, uncached repeat", req_count - n0, 1);
    report("uncached fetches", e0);
  endtask

  task automatic exception_fetches();
    int e0;
    int n0;
    e0 = errors;
    csr_i = '{plv: 2'd0, da: 1'b0};
    map_page(20'h00023, 20'h00400, 1'b0, 2'd3, 1'b1);   // page not valid
    map_page(20'h00034, 20'h00401, 1'b1, 2'd0, 1'b1);   // privilege 0 only
    n0 = req_count;
    fetch(32'h0001_2002, 2'b01, 32'h41, 32'h0, EX_ADEF);
    fetch(32'h0005_5000, 2'b11, 32'h42, 32'h0, EX_TLBR);   // nothing mapped at index 5
    fetch(32'h0002_3000, 2'b11, 32'h43, 32'h0, EX_PIF);
    drain();
    csr_i.plv = 2'd3;
    fetch(32'h0003_4000, 2'b11, 32'h44, 32'h0, EX_PPI);
    drain();
    csr_i.plv = 2'd0;
    check("bus requests for exceptions", req_count - n0, 0);
    report("exception fetches", e0);
  endtask

  task automatic backpressure_stream();
    int e0;
    int n0;
    int i;
    logic [31:0] pc;
    e0 = errors;
    csr_i = '{plv: 2'd0, da: 1'b1};
    n0 = req_count;
    bp_mode = 1'b1;
    // four lines, each first touched once, the rest hits
    for (i = 0; i < 16; i++)
    begin
      pc = 32'h0000_5000 + 32'(((i * 5) % 8) * 8);
      fetch(pc, 2'b11, 32'h500 + 32'(i), pc, EX_NONE);
    end
    drain();
    bp_mode = 1'b0;
    check("bus requests under back-pressure", req_count - n0, 4);
    report("back-pressure stream", e0);
  endtask

  task automatic flush_in_flight();
    int e0;
    int n0;
    e0 = errors;
    csr_i = '{plv: 2'd0, da: 1'b1};
    n0 = req_count;
    issue(32'h0000_4020, 2'b11, 32'h60);   // dropped by the flush
    while (!bus_req_o.valid)
      @(negedge clk);
    flush_i = 1'b1;
    @(negedge clk);
    flush_i = 1'b0;
    fetch(32'h0000_4020, 2'b11, 32'h61, 32'h0000_4020, EX_NONE);
    fetch(32'h0000_4028, 2'b11, 32'h62, 32'h0000_4028, EX_NONE);
    drain();
    check("bus requests around flush", req_count - n0, 1);
    report("flush in flight", e0);
  endtask

  task automatic replacement_and_forwarding();
    int e0;
    int n0;
    int i;
    logic [31:0] pc;
    e0 = errors;
    csr_i = '{plv: 2'd0, da: 1'b1};
    n0 = req_count;
    // tags 0x10 to 0x14 into set 0x25, then the first tag again
    for (i = 0; i < 6; i++)
    begin
      pc = 32'h0001_0250 + 32'((i % 5) << 12);
      fetch(pc, 2'b11, 32'h700 + 32'(i), pc, EX_NONE);
      drain();
    end
    check("bus requests for six fetches", req_count - n0, 6);
    n0 = req_count;
    fetch(32'h0002_0250, 2'b11, 32'h710, 32'h0002_0250, EX_NONE);
    fetch(32'h0002_0258, 2'b11, 32'h711, 32'h0002_0258, EX_NONE);   // waits in F1
    drain();
    check("bus requests, same line behind a refill", req_count - n0, 1);
    n0 = req_count;
    // the refill for tag 0x21 replaces tag 0x13 under the stalled fetch
    fetch(32'h0002_1250, 2'b11, 32'h712, 32'h0002_1250, EX_NONE);
    fetch(32'h0001_3250, 2'b11, 32'h713, 32'h0001_3250, EX_NONE);
    drain();
    check("bus requests, evicted line behind a refill", req_count - n0, 2);
    report("replacement and forwarding", e0);
  endtask

  initial
  begin
    void'($urandom(32'ha681ece3));
    rst_n        = 1'b0;
    f_valid_i    = 1'b0;
    f_pc_i       = '0;
    f_mask_i     = '0;
    f_pkg_i      = '0;
    csr_i        = '0;
    tlb_update_i = '0;
    flush_i      = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    miss_then_hit();
    uncached_fetches();
    exception_fetches();
    backpressure_stream();
    flush_in_flight();
    replacement_and_forwarding();
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// File: src.f
hdl/icache_pkg.sv
hdl/icache_tlb.sv
hdl/icache_way.sv
hdl/icache_refill.sv
hdl/icache_fetch.sv
hdl/icache_top.sv
test/tb_icache.sv

// File: run.sh
#!/usr/bin/env bash
# builds the instruction cache testbench with Verilator, runs it and checks the result
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_icache \
  -Mdir obj_dir -o sim_icache
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/sim_icache)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Test OK"; then
  exit 0
else
  echo "pass message not found in simulation output"
  exit 1
fi
